/* source/xecuPkg.sv */
`default_nettype none

package xecuPkg;

   // Which functional unit drives the stage result
   typedef enum logic [2:0] {
      selAdd = 3'd0,
      selLog = 3'd1,
      selSft = 3'd2,
      selMov = 3'd3,
      selMul = 3'd4,
      selBsf = 3'd5
   } aluSel;

   // Decoded fields handed over by decode
   typedef struct packed {
      logic [5:0]  opcode;
      logic [15:0] imm;    // Raw immediate, also function bits
      logic [10:0] alt;    // Barrel shift kind in [10:9]
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [1:0]  mxSrc;  // Operand A source
      logic [1:0]  mxTgt;  // Operand B source
      aluSel       mxAlu;
      logic [31:0] simm;   // Sign-extended immediate
      logic        skip;   // Squashed instruction
   } execCmd;

   // Machine status flags kept by the stage
   typedef struct packed {
      logic c;
      logic ie;
      logic be;
      logic bip;
   } msrState;

   // Opcodes the stage decodes on its own
   localparam logic [5:0] opSpecial = 6'o45;  // mts, mfs
   localparam logic [5:0] opReturn  = 6'o55;  // rtsd, rtid, rtbd
   localparam logic [5:0] opBrk     = 6'o56;
   localparam logic [5:0] opBrki    = 6'o66;

endpackage

`default_nettype wire

/* source/operandSelect.sv */
`timescale 1ns/100ps
`default_nettype none

module operandSelect (
   input  var xecuPkg::execCmd cmd,
   input  wire logic [31:0]    regA,
   input  wire logic [31:0]    regB,
   input  wire logic [31:0]    dwbDi,
   input  wire logic [29:0]    pc,
   input  wire logic [31:0]    rResult,
   output logic [31:0]         opA,
   output logic [31:0]         opB
);

   // Operand A
   always_comb begin
      case (cmd.mxSrc)
         2'd0: opA = regA;
         2'd1: opA = rResult;          // Forward from this stage
         2'd2: opA = dwbDi;            // Forward load data
         2'd3: opA = {pc, 2'b00};      // Word address as byte address
         default: opA = regA;
      endcase
   end

   // Operand B
   always_comb begin
      case (cmd.mxTgt)
         2'd0: opB = regB;
         2'd1: opB = rResult;
         2'd2: opB = dwbDi;
         2'd3: opB = cmd.simm;         // Immediate forms
         default: opB = regB;
      endcase
   end

endmodule

`default_nettype wire

/* source/integerUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module integerUnit (
   input  wire logic             gclk,
   input  wire logic             grst,
   input  var xecuPkg::execCmd   cmd,
   input  wire logic [31:0]      opA,
   input  wire logic [31:0]      opB,
   input  var xecuPkg::msrState  msr,
   input  wire logic [29:0]      pc,
   output logic [31:0]           addRes,
   output logic [31:0]           logRes,
   output logic [31:0]           sftRes,
   output logic [31:0]           movRes,
   output logic                  addCarry,
   output logic                  sftCarry,
   output logic [3:0]            dwbSel
);

   localparam logic [19:0] msrVersion = 20'h0ED32;

   logic        useCarry;
   logic        isSub;
   logic        isCmpu;
   logic [31:0] addInA;
   logic        addCin;
   logic [31:0] addSum;
   logic [31:0] msrWord;
   logic        isMfs;
   logic        isMfpc;
   logic [3:0]  dwbSelNext;

   // Adder with carry in and out
   assign useCarry = !cmd.opcode[5] & cmd.opcode[1];   // addc, rsubc
   assign isSub    = !cmd.opcode[5] & cmd.opcode[0];
   assign isCmpu   = (cmd.opcode[5:3] == 3'b000) & cmd.imm[1];   // Register add group only
   assign addInA   = isSub ? ~opA : opA;               // B - A as B + ~A + 1
   assign addCin   = useCarry ? msr.c : isSub;

   assign {addCarry, addSum} = {1'b0, opB} + {1'b0, addInA} + {32'h0, addCin};

   // Unsigned compare puts the borrow in the sign bit
   assign addRes = {(isCmpu ? !addCarry : addSum[31]), addSum[30:0]};

   always_comb begin
      case (cmd.opcode[1:0])
         2'd0: logRes = opA | opB;
         2'd1: logRes = opA & opB;
         2'd2: logRes = opA ^ opB;
         default: logRes = opA & ~opB;   // andn
      endcase
   end

   // One-bit right shifts and sign extension
   always_comb begin
      sftCarry = opA[0];
      case (cmd.imm[6:5])
         2'd0: sftRes = {opA[31], opA[31:1]};     // sra
         2'd1: sftRes = {msr.c, opA[31:1]};       // src
         2'd2: sftRes = {1'b0, opA[31:1]};        // srl
         default: begin
            sftCarry = msr.c;                     // Sign extension keeps carry
            if (cmd.imm[0]) begin
               sftRes = {{16{opA[15]}}, opA[15:0]};
            end else begin
               sftRes = {{24{opA[7]}}, opA[7:0]};
            end
         end
      endcase
   end

   // Status word as read back by mfs
   assign msrWord = {msr.c, 3'b000, msrVersion, 4'h0, msr.bip, msr.c, msr.ie, msr.be};

   assign isMfs  = (cmd.opcode == xecuPkg::opSpecial) & !cmd.imm[14] & cmd.imm[0];
   assign isMfpc = (cmd.opcode == xecuPkg::opSpecial) & !cmd.imm[14] & !cmd.imm[0];

   always_comb begin
      if (isMfs) begin
         movRes = msrWord;
      end else if (isMfpc) begin
         movRes = {pc, 2'b00};
      end else if (cmd.ra[3]) begin
         movRes = opB;
      end else begin
         movRes = opA;
      end
   end

   // Byte lanes from access size and address, big endian
   always_comb begin
      case (cmd.opcode[1:0])
         2'd0: dwbSelNext = 4'h8 >> addSum[1:0];          // Byte
         2'd1: dwbSelNext = addSum[1] ? 4'h3 : 4'hC;      // Halfword
         2'd2: dwbSelNext = 4'hF;                         // Word
         default: dwbSelNext = 4'h0;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         dwbSel <= 4'h0;
      end else begin
         dwbSel <= dwbSelNext;
      end
   end

endmodule

`default_nettype wire

/* source/auxUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module auxUnit #(
   parameter bit useMul = 1'b0,
   parameter bit useBsf = 1'b0
) (
   input  wire logic            gclk,
   input  wire logic            grst,
   input  wire logic            xEn,
   input  var xecuPkg::execCmd  cmd,
   input  wire logic [31:0]     opA,
   input  wire logic [31:0]     opB,
   output logic [31:0]          mulRes,
   output logic [31:0]          bsfRes
);

   // Both units load during the stall cycle, when xEn is low
   generate
      if (useMul) begin : genMul
         logic [31:0] mulReg;

         always_ff @(posedge gclk) begin
            if (grst) begin
               mulReg <= 32'h0;
            end else if (!xEn) begin
               mulReg <= opA * opB;   // Low word of product
            end
         end

         assign mulRes = mulReg;
      end else begin : genNoMul
         assign mulRes = 32'h0;
      end
   endgenerate

   generate
      if (useBsf) begin : genBsf
         logic [31:0] bsfNext;
         logic [31:0] bsfReg;

         always_comb begin
            case (cmd.alt[10:9])
               2'd0: bsfNext = opA >> opB[4:0];
               2'd1: bsfNext = $unsigned($signed(opA) >>> opB[4:0]);
               2'd2: bsfNext = opA << opB[4:0];
               default: bsfNext = 32'h0;   // Unused code
            endcase
         end

         always_ff @(posedge gclk) begin
            if (grst) begin
               bsfReg <= 32'h0;
            end else if (!xEn) begin
               bsfReg <= bsfNext;
            end
         end

         assign bsfRes = bsfReg;
      end else begin : genNoBsf
         assign bsfRes = 32'h0;
      end
   endgenerate

endmodule

`default_nettype wire

/* source/msrFile.sv */
`timescale 1ns/100ps
`default_nettype none

module msrFile (
   input  wire logic            gclk,
   input  wire logic            grst,
   input  wire logic            xEn,
   input  var xecuPkg::execCmd  cmd,
   input  wire logic [31:0]     opA,
   input  wire logic            addCarry,
   input  wire logic            sftCarry,
   output xecuPkg::msrState     msr
);

   xecuPkg::msrState msrNext;

   logic isMts;
   logic writesCarry;
   logic isBranch;
   logic isRtid;
   logic isRtbd;
   logic isBrk;
   logic isInt;

   assign isMts       = (cmd.opcode == xecuPkg::opSpecial) & cmd.imm[14] & !cmd.skip;
   assign writesCarry = ({cmd.opcode[5:4], cmd.opcode[2]} == 3'b000);   // Not the K forms

   assign isBranch = (cmd.opcode == xecuPkg::opBrk) | (cmd.opcode == xecuPkg::opBrki);
   assign isRtid   = (cmd.opcode == xecuPkg::opReturn) & cmd.rd[0] & !cmd.skip;
   assign isRtbd   = (cmd.opcode == xecuPkg::opReturn) & cmd.rd[1] & !cmd.skip;
   assign isBrk    = isBranch & (cmd.ra == 5'h0C) & !cmd.skip;   // brk to r12... link
   assign isInt    = isBranch & (cmd.ra == 5'h0E) & !cmd.skip;

   always_comb begin
      msrNext = msr;

      // Carry
      if (!cmd.skip) begin
         case (cmd.mxAlu)
            xecuPkg::selAdd: msrNext.c = writesCarry ? addCarry : msr.c;
            xecuPkg::selSft: msrNext.c = sftCarry;
            xecuPkg::selMov: msrNext.c = isMts ? opA[2] : msr.c;
            default: msrNext.c = msr.c;
         endcase
      end

      if (isInt) begin
         msrNext.ie = 1'b0;
      end else if (isRtid) begin
         msrNext.ie = 1'b1;
      end else if (isMts) begin
         msrNext.ie = opA[1];
      end

      if (isBrk) begin
         msrNext.bip = 1'b1;
      end else if (isRtbd) begin
         msrNext.bip = 1'b0;
      end else if (isMts) begin
         msrNext.bip = opA[3];
      end

      if (isMts) msrNext.be = opA[0];
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         msr <= '0;
      end else if (xEn) begin
         msr <= msrNext;
      end
   end

endmodule

`default_nettype wire

/* source/executeUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module executeUnit #(
   parameter bit useMul = 1'b0,
   parameter bit useBsf = 1'b0
) (
   input  wire logic            gclk,
   input  wire logic            grst,
   input  var xecuPkg::execCmd  cmd,
   input  wire logic [31:0]     regA,
   input  wire logic [31:0]     regB,
   input  wire logic [31:0]     dwbDi,    // Load data
   input  wire logic [29:0]     pc,
   input  wire logic            xEn,      // Stage advance
   output logic [31:0]          xResult,
   output logic [31:0]          rResult,
   output logic [3:0]           dwbSel,
   output logic                 msrIe,
   output logic [31:0]          precycleAddr
);

   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] addRes;
   logic [31:0] logRes;
   logic [31:0] sftRes;
   logic [31:0] movRes;
   logic [31:0] mulRes;
   logic [31:0] bsfRes;
   logic        addCarry;
   logic        sftCarry;

   xecuPkg::msrState msr;

   operandSelect operandSelect_inst (
      .cmd(cmd), .regA(regA), .regB(regB), .dwbDi(dwbDi), .pc(pc),
      .rResult(rResult), .opA(opA), .opB(opB)
   );

   integerUnit integerUnit_inst (
      .gclk(gclk), .grst(grst), .cmd(cmd), .opA(opA), .opB(opB), .msr(msr), .pc(pc),
      .addRes(addRes), .logRes(logRes), .sftRes(sftRes), .movRes(movRes),
      .addCarry(addCarry), .sftCarry(sftCarry), .dwbSel(dwbSel)
   );

   auxUnit #(.useMul(useMul), .useBsf(useBsf)) auxUnit_inst (
      .gclk(gclk), .grst(grst), .xEn(xEn), .cmd(cmd), .opA(opA), .opB(opB),
      .mulRes(mulRes), .bsfRes(bsfRes)
   );

   msrFile msrFile_inst (
      .gclk(gclk), .grst(grst), .xEn(xEn), .cmd(cmd), .opA(opA),
      .addCarry(addCarry), .sftCarry(sftCarry), .msr(msr)
   );

   // Result mux
   always_comb begin
      case (cmd.mxAlu)
         xecuPkg::selAdd: xResult = addRes;
         xecuPkg::selLog: xResult = logRes;
         xecuPkg::selSft: xResult = sftRes;
         xecuPkg::selMov: xResult = movRes;
         xecuPkg::selMul: xResult = mulRes;   // Zero when unit is left out
         xecuPkg::selBsf: xResult = bsfRes;
         default: xResult = 32'h0;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         rResult <= 32'h0;
      end else if (xEn) begin
         rResult <= xResult;
      end
   end

   assign msrIe = msr.ie;

   // Cache index order, region bits kept on top
   assign precycleAddr = {xResult[31:29], 2'b00, xResult[28:2]};

endmodule

`default_nettype wire

/* tb/executeChecker.sv */
`timescale 1ns/100ps
`default_nettype none

module executeChecker (
   input  wire logic        gclk,
   input  wire logic        grst,
   input  wire logic        xEn,          // Stage advance of the line now on the inputs
   input  wire logic        expValid,     // Expected values below belong to this cycle
   input  wire logic [31:0] expResult,
   input  wire logic [3:0]  expSel,
   input  wire logic        selValid,     // Low when the line does not care about dwbSel
   input  wire logic        expIe,
   input  wire logic [31:0] xResult,
   input  wire logic [31:0] rResult,
   input  wire logic [3:0]  dwbSel,
   input  wire logic        msrIe,
   input  wire logic [31:0] precycleAddr,
   output int               errorCount,
   output int               checkCount
);

   logic        armed;
   logic        selArmed;
   logic [31:0] heldResult;
   logic [3:0]  heldSel;
   logic        heldIe;
   logic [31:0] addrExpected;

   initial begin
      errorCount = 0;
      checkCount = 0;
   end

   // Expected values for the edge that is just taking place
   always @(posedge gclk) begin
      armed      <= expValid & !grst;
      selArmed   <= expValid & selValid & !grst;
      heldResult <= expResult;
      heldSel    <= expSel;
      heldIe     <= expIe;
   end

   // Registered outputs have settled by the falling edge
   always @(negedge gclk) begin
      if (armed) begin
         checkCount = checkCount + 2;
         if (rResult !== heldResult) begin
            $display("Fail %0t: rResult expected %h, got %h", $time, heldResult, rResult);
            errorCount = errorCount + 1;
         end
         if (msrIe !== heldIe) begin
            $display("Fail %0t: msrIe expected %b, got %b", $time, heldIe, msrIe);
            errorCount = errorCount + 1;
         end
      end
      if (selArmed) begin
         checkCount = checkCount + 1;
         if (dwbSel !== heldSel) begin
            $display("Fail %0t: dwbSel expected %h, got %h", $time, heldSel, dwbSel);
            errorCount = errorCount + 1;
         end
      end
      // Combinational outputs of the line on the inputs now
      if (expValid && xEn && !grst) begin
         // Region bits stay, word index moves down by two
         addrExpected = (expResult & 32'hE000_0000) | ((expResult & 32'h1FFF_FFFC) >> 2);
         checkCount = checkCount + 2;
         if (xResult !== expResult) begin
            $display("Fail %0t: xResult expected %h, got %h", $time, expResult, xResult);
            errorCount = errorCount + 1;
         end
         if (precycleAddr !== addrExpected) begin
            $display("Fail %0t: precycleAddr expected %h, got %h", $time, addrExpected,
                     precycleAddr);
            errorCount = errorCount + 1;
         end
      end
   end

endmodule

`default_nettype wire

/* tb/executeUnitTb.sv */
`timescale 1ns/100ps
`default_nettype none

module executeUnitTb;

   localparam int fieldCount = 18;   // Words per stimulus line
   localparam int maxVectors = 64;

   logic             gclk;
   logic             grst;
   xecuPkg::execCmd  cmd;
   logic [31:0]      regA;
   logic [31:0]      regB;
   logic [31:0]      dwbDi;
   logic [29:0]      pc;
   logic             xEn;
   logic [31:0]      xResult;
   logic [31:0]      rResult;
   logic [3:0]       dwbSel;
   logic             msrIe;
   logic [31:0]      precycleAddr;

   logic             expValid;
   logic [31:0]      expResult;
   logic [3:0]       expSel;
   logic             selValid;
   logic             expIe;
   int               errorCount;
   int               checkCount;
   int               vectorCount;
   logic             loaded;

   logic [31:0] vecMem [0:fieldCount*maxVectors-1];

   executeUnit #(.useMul(1'b1), .useBsf(1'b1)) executeUnit_inst (
      .gclk(gclk), .grst(grst), .cmd(cmd), .regA(regA), .regB(regB), .dwbDi(dwbDi),
      .pc(pc), .xEn(xEn), .xResult(xResult), .rResult(rResult), .dwbSel(dwbSel),
      .msrIe(msrIe), .precycleAddr(precycleAddr)
   );

   executeChecker executeChecker_inst (
      .gclk(gclk), .grst(grst), .xEn(xEn), .expValid(expValid), .expResult(expResult),
      .expSel(expSel), .selValid(selValid), .expIe(expIe), .xResult(xResult),
      .rResult(rResult), .dwbSel(dwbSel), .msrIe(msrIe), .precycleAddr(precycleAddr),
      .errorCount(errorCount), .checkCount(checkCount)
   );

   initial gclk = 1'b0;
   always #4 gclk = ~gclk;

   // Puts one stimulus line on the DUT inputs and the checker inputs
   task automatic applyVector(input int idx);
      int base;
      base = idx * fieldCount;
      cmd.opcode = vecMem[base][5:0];
      cmd.imm    = vecMem[base+1][15:0];
      cmd.alt    = vecMem[base+2][10:0];
      cmd.rd     = vecMem[base+3][4:0];
      cmd.ra     = vecMem[base+4][4:0];
      cmd.mxSrc  = vecMem[base+5][1:0];
      cmd.mxTgt  = vecMem[base+6][1:0];
      cmd.mxAlu  = xecuPkg::aluSel'(vecMem[base+7][2:0]);
      cmd.simm   = vecMem[base+8];
      cmd.skip   = vecMem[base+9][0];
      regA       = vecMem[base+10];
      regB       = vecMem[base+11];
      dwbDi      = vecMem[base+12];
      pc         = vecMem[base+13][29:0];
      xEn        = vecMem[base+14][0];
      expResult  = vecMem[base+15];
      expSel     = vecMem[base+16][3:0];
      selValid   = (vecMem[base+16] < 32'h10);
      expIe      = vecMem[base+17][0];
      // Load data and pc are free when no operand reads them
      if (cmd.mxSrc != 2'd2 && cmd.mxTgt != 2'd2) begin
         dwbDi = $urandom;
      end
      if (cmd.mxSrc != 2'd3 && cmd.opcode != xecuPkg::opSpecial) begin
         pc = 30'($urandom);
      end
      expValid = 1'b1;
   endtask

   initial begin
      void'($urandom(32'heb1c_fa87));
      grst        = 1'b1;
      cmd         = '0;
      regA        = 32'h0;
      regB        = 32'h0;
      dwbDi       = 32'h0;
      pc          = 30'h0;
      xEn         = 1'b0;
      expValid    = 1'b0;
      expResult   = 32'h0;
      expSel      = 4'h0;
      selValid    = 1'b0;
      expIe       = 1'b0;
      vectorCount = 0;
      loaded      = 1'b0;

      for (int k = 0; k < fieldCount*maxVectors; k++) begin
         vecMem[k] = 32'hF000_0000 | k;   // Never a 6-bit opcode
      end
      $readmemh("tb/execute_stimulus.txt", vecMem);
      while (vectorCount < maxVectors && vecMem[vectorCount*fieldCount] < 32'h40) begin
         vectorCount = vectorCount + 1;
      end
      loaded = 1'b1;
      if (vectorCount == 0) begin
         $display("No stimulus lines could be read from tb/execute_stimulus.txt");
      end

      repeat (2) @(posedge gclk);
      #1 grst = 1'b0;
      for (int i = 0; i < vectorCount; i++) begin
         if (i > 0) begin
            @(posedge gclk);
            #1;
         end
         applyVector(i);
      end
      @(posedge gclk);
      #1 expValid = 1'b0;
      xEn = 1'b0;
      @(negedge gclk);
      #1;

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0 && checkCount > 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog sized from the number of stimulus lines
   initial begin
      wait (loaded);
      #((vectorCount + 10) * 8);
      $display("Timeout: the run did not finish within %0d cycles", vectorCount + 10);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/execute_stimulus.txt */
// opcode imm alt rd ra mxSrc mxTgt mxAlu simm skip regA regB dwbDi pc xEn
// then expected rResult, dwbSel (ff when not checked) and msrIe, all hex
00 0000 000 00 00 0 0 0 00000000 0 fffffff0 00000020 0 0 1 00000010 ff 0
02 0000 000 00 00 0 0 0 00000000 0 00000001 00000002 0 0 1 00000004 ff 0
01 0000 000 00 00 0 0 0 00000000 0 00000005 00000003 0 0 1 fffffffe ff 0
03 0000 000 00 00 0 0 0 00000000 0 00000001 00000010 0 0 1 0000000e ff 0
05 0003 000 00 00 0 0 0 00000000 0 00000001 ffffffff 0 0 1 7ffffffe ff 0
05 0003 000 00 00 0 0 0 00000000 0 80000000 00000001 0 0 1 80000001 ff 0
20 0000 000 00 00 0 0 1 00000000 0 f0f00000 0000ff0f 0 0 1 f0f0ff0f ff 0
21 0000 000 00 00 0 0 1 00000000 0 ff00ff00 0f0f0f0f 0 0 1 0f000f00 ff 0
22 0000 000 00 00 0 0 1 00000000 0 aaaa5555 ffff0000 0 0 1 55555555 ff 0
23 0000 000 00 00 0 0 1 00000000 0 ffffffff 0000ffff 0 0 1 ffff0000 ff 0
24 0000 000 00 00 0 0 2 00000000 0 80000003 00000000 0 0 1 c0000001 ff 0
24 0020 000 00 00 0 0 2 00000000 0 00000004 00000000 0 0 1 80000002 ff 0
24 0020 000 00 00 0 0 2 00000000 0 00000001 00000000 0 0 1 00000000 ff 0
24 0040 000 00 00 0 0 2 00000000 0 80000000 00000000 0 0 1 40000000 ff 0
24 0060 000 00 00 0 0 2 00000000 0 12345680 00000000 0 0 1 ffffff80 ff 0
24 0061 000 00 00 0 0 2 00000000 0 00008001 00000000 0 0 1 ffff8001 ff 0
25 4000 000 00 00 0 0 3 00000000 0 0000000a 00000000 0 0 1 0000000a ff 1
36 0010 000 00 0e 0 3 0 00000010 0 00000100 00000000 0 0 1 00000110 ff 0
2d 0000 000 11 00 0 0 0 00000000 1 00000200 00000004 0 0 1 00000204 ff 0
2d 0000 000 11 00 0 0 0 00000000 0 00000300 00000008 0 0 1 00000308 ff 1
25 0001 000 00 00 0 0 3 00000000 0 00000000 00000000 0 0 1 00ed320a ff 1
25 4000 000 00 00 0 0 3 00000000 1 00000000 00000000 0 0 1 00000000 ff 1
25 4000 000 00 00 0 0 3 00000000 0 00000004 00000000 0 0 1 00000004 ff 0
10 0000 000 00 00 0 0 4 00000000 0 00012345 00100001 0 0 0 00000004 ff 0
10 0000 000 00 00 0 0 4 00000000 0 00012345 00100001 0 0 1 34512345 ff 0
11 0000 000 00 00 0 0 5 00000000 0 80000000 00000004 0 0 0 34512345 ff 0
11 0000 000 00 00 0 0 5 00000000 0 80000000 00000004 0 0 1 08000000 ff 0
11 0000 200 00 00 0 0 5 00000000 0 80000000 00000004 0 0 0 08000000 ff 0
11 0000 200 00 00 0 0 5 00000000 0 80000000 00000004 0 0 1 f8000000 ff 0
11 0000 400 00 00 0 0 5 00000000 0 00000001 0000001f 0 0 0 f8000000 ff 0
11 0000 400 00 00 0 0 5 00000000 0 00000001 0000001f 0 0 1 80000000 ff 0
34 0001 000 00 00 0 3 0 00000001 0 00001000 00000000 0 0 1 00001001 04 0
35 0002 000 00 00 0 3 0 00000002 0 00002000 00000000 0 0 1 00002002 03 0
32 0004 000 00 00 0 3 0 00000004 0 00003000 00000000 0 0 1 00003004 0f 0
34 0003 000 00 00 0 3 0 00000003 0 e0000000 00000000 0 0 1 e0000003 01 0
00 0000 000 00 00 1 0 0 00000000 0 00000000 00000010 0 0 1 e0000013 ff 0
20 0000 000 00 00 2 1 1 00000000 0 00000000 00000000 0000ff00 0 1 e000ff13 ff 0
00 0000 000 00 00 0 0 0 00000000 0 00000001 00000001 0 0 0 e000ff13 ff 0
00 0000 000 00 00 3 0 0 00000000 0 00000000 00000005 0 00000400 1 00001005 ff 0

/* filelist.f */
source/xecuPkg.sv
source/operandSelect.sv
source/integerUnit.sv
source/auxUnit.sv
source/msrFile.sv
source/executeUnit.sv
tb/executeChecker.sv
tb/executeUnitTb.sv

/* runSim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module executeUnitTb -f filelist.f -Mdir obj_dir \
   > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/VexecuteUnitTb > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation gave no result"; exit 1; }
exit 0
